// File: perf_monitor.f
+incdir+source
source/hpm_pkg.sv
source/hpm_event_capture.sv
source/hpm_counter.sv
source/hpm_wb_regs.sv
source/perf_monitor_top.sv
verification/tb_perf_monitor.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the performance monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    -f perf_monitor.f \
    --top-module tb_perf_monitor \
    -o sim_perf_monitor

./obj_dir/sim_perf_monitor | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: source/hpm_counter.sv
// One programmable event counter with its selector, inhibit and wrap detect
// Loaded and programmed through the write command from the register block
`timescale 1ns/1ns

`include "hpm_defs.svh"

module hpm_counter (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  hpm_pkg::hpm_events_t  events_i,
    input  logic                  inhibit_i,
    input  hpm_pkg::hpm_wr_t      wr_i,
    output hpm_pkg::hpm_cnt_t     count_o,
    output hpm_pkg::event_sel_t   sel_o,
    output logic                  ovf_o
);

    import hpm_pkg::*;

    localparam int IDX_W = $clog2(`HPM_NUM_EVENTS);

    event_sel_t       sel_q;
    hpm_cnt_t         count_q;
    logic             ovf_q;
    logic [IDX_W-1:0] sel_idx;    // Event line picked by the selector
    logic             sel_valid;  // Selector points at a real event
    logic             inc;

    // --------------------------------------------------
    // Event selection
    // --------------------------------------------------
    assign sel_idx   = IDX_W'(sel_q - 1'b1);
    assign sel_valid = (sel_q != '0) && (sel_q <= `HPM_NUM_EVENTS);
    assign inc       = sel_valid && events_i[sel_idx] && !inhibit_i;

    // --------------------------------------------------
    // Selector and count
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sel_q   <= '0;
            count_q <= '0;
            ovf_q   <= 1'b0;
        end else begin
            if (wr_i.sel_we) begin
                sel_q <= event_sel_t'(wr_i.data);      // Low 5 bits only
            end
            if (wr_i.cnt_we) begin
                count_q <= hpm_cnt_t'(wr_i.data);      // Write beats increment
            end else if (inc) begin
                count_q <= count_q + 1'b1;
            end
            // Pulse on the wrap edge
            ovf_q <= inc && !wr_i.cnt_we && (count_q == '1);
        end
    end

    assign count_o = count_q;
    assign sel_o   = sel_q;
    assign ovf_o   = ovf_q;

    // Overflow only right after an all-ones count
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        ovf_q |-> ($past(count_q) == '1))
        else $error("hpm_counter: ovf without all-ones count");

endmodule

// File: source/hpm_defs.svh
// Sizes, widths and the Wishbone register map of the performance monitor
// Included by the package and by every RTL file that needs a constant
`ifndef HPM_DEFS_SVH
`define HPM_DEFS_SVH

// --------------------------------------------------
// Sizes and widths
// --------------------------------------------------
`define HPM_NUM_COUNTERS      4       // Programmable counters
`define HPM_NUM_EVENTS        16      // Event lines, selector 0 is no event
`define HPM_CNT_WIDTH         32      // Counter width
`define WB_ADDR_WIDTH         8       // Byte address
`define WB_DATA_WIDTH         32

// --------------------------------------------------
// Register map, byte offsets
// --------------------------------------------------
`define HPM_ADDR_MCYCLE       8'h00   // Cycle counter
`define HPM_ADDR_INHIBIT      8'h04   // Bit 0 mcycle, bit 3+k counter k
`define HPM_ADDR_OVF          8'h08   // Overflow status, write 1 to clear
`define HPM_ADDR_IRQ_EN       8'h0C   // Overflow interrupt enables
`define HPM_ADDR_COUNTER_BASE 8'h10   // Counter k at base + 4*k
`define HPM_ADDR_EVSEL_BASE   8'h20   // Event selector k at base + 4*k
`define HPM_CNT_FIRST_BIT     3       // Counter 0 position in mask registers

`endif

// File: source/hpm_event_capture.sv
// Event capture stage, orders core and memory flags into the event numbering
// and registers them for one cycle ahead of the counters
`timescale 1ns/1ns

module hpm_event_capture (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  hpm_pkg::core_events_t  core_events_i,
    input  hpm_pkg::mem_events_t   mem_events_i,
    output hpm_pkg::hpm_events_t   events_o
);

    import hpm_pkg::*;

    hpm_events_t events_d;  // Numbered event lines, unregistered
    hpm_events_t events_q;

    // --------------------------------------------------
    // Event numbering, bit i-1 is event i
    // --------------------------------------------------
    always_comb begin
        // Core events in the lower half
        events_d[0]  = core_events_i.branch_miss;   // 1
        events_d[1]  = core_events_i.is_branch;     // 2
        events_d[2]  = core_events_i.branch_taken;  // 3
        events_d[3]  = core_events_i.stall_if;      // 4
        events_d[4]  = core_events_i.stall_id;      // 5
        events_d[5]  = core_events_i.stall_exe;     // 6
        events_d[6]  = core_events_i.stall_wb;      // 7
        events_d[7]  = core_events_i.load_store;    // 8
        // Memory system events in the upper half
        events_d[8]  = mem_events_i.icache_req;     // 9
        events_d[9]  = mem_events_i.icache_miss;    // 10
        events_d[10] = mem_events_i.dcache_read;    // 11
        events_d[11] = mem_events_i.dcache_write;   // 12
        events_d[12] = mem_events_i.dcache_miss;    // 13
        events_d[13] = mem_events_i.itlb_miss;      // 14
        events_d[14] = mem_events_i.dtlb_miss;      // 15
        events_d[15] = mem_events_i.dcache_stall;   // 16
    end

    // --------------------------------------------------
    // Pipeline register
    // --------------------------------------------------
    // Breaks the path from the core flags to the counter adders. A new
    // set of flags is taken every cycle while the counters add the last one.
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            events_q <= '0;              // Hard reset only
        end else begin
            events_q <= events_d;
        end
    end

    assign events_o = events_q;

endmodule

// File: source/hpm_pkg.sv
// Types shared by the performance monitor blocks
// Event flag groups, counter and bus word types, per-counter write command
package hpm_pkg;

`include "hpm_defs.svh"

    // --------------------------------------------------
    // Event flag groups
    // --------------------------------------------------
    typedef struct packed {
        logic branch_miss;   // Event 1
        logic is_branch;     // Event 2
        logic branch_taken;  // Event 3
        logic stall_if;      // Event 4
        logic stall_id;      // Event 5
        logic stall_exe;     // Event 6
        logic stall_wb;      // Event 7
        logic load_store;    // Event 8
    } core_events_t;

    typedef struct packed {
        logic icache_req;    // Event 9
        logic icache_miss;   // Event 10
        logic dcache_read;   // Event 11
        logic dcache_write;  // Event 12
        logic dcache_miss;   // Event 13
        logic itlb_miss;     // Event 14
        logic dtlb_miss;     // Event 15
        logic dcache_stall;  // Event 16
    } mem_events_t;

    // --------------------------------------------------
    // Vectors
    // --------------------------------------------------
    typedef logic [`HPM_NUM_EVENTS-1:0]             hpm_events_t;  // Bit i-1 is event i
    typedef logic [$clog2(`HPM_NUM_EVENTS+1)-1:0]   event_sel_t;
    typedef logic [`HPM_CNT_WIDTH-1:0]              hpm_cnt_t;
    typedef logic [`WB_ADDR_WIDTH-1:0]              wb_addr_t;
    typedef logic [`WB_DATA_WIDTH-1:0]              wb_data_t;
    typedef logic [`WB_DATA_WIDTH-1:0]              hpm_mask_t;

    // One counter's write command from the register block
    typedef struct packed {
        logic     cnt_we;    // Load count
        logic     sel_we;    // Load event selector
        wb_data_t data;
    } hpm_wr_t;

endpackage

// File: source/hpm_wb_regs.sv
// Wishbone classic slave for the counter bank, holds mcycle and the control
// registers, drives per-counter write commands and the overflow interrupt
`timescale 1ns/1ns

`include "hpm_defs.svh"

module hpm_wb_regs (
    input  logic                                               clk_i,
    input  logic                                               rstn_i,
    input  logic                                               wb_cyc_i,
    input  logic                                               wb_stb_i,
    input  logic                                               wb_we_i,
    input  hpm_pkg::wb_addr_t                                  wb_adr_i,
    input  hpm_pkg::wb_data_t                                  wb_dat_i,
    output hpm_pkg::wb_data_t                                  wb_dat_o,
    output logic                                               wb_ack_o,
    input  hpm_pkg::hpm_cnt_t   [`HPM_NUM_COUNTERS-1:0]        cnt_i,
    input  hpm_pkg::event_sel_t [`HPM_NUM_COUNTERS-1:0]        sel_i,
    input  logic                [`HPM_NUM_COUNTERS-1:0]        ovf_i,
    output hpm_pkg::hpm_wr_t    [`HPM_NUM_COUNTERS-1:0]        cnt_wr_o,
    output logic                [`HPM_NUM_COUNTERS-1:0]        inhibit_o,
    output logic                                               ovf_irq_o
);

    import hpm_pkg::*;

    localparam int NCNT = `HPM_NUM_COUNTERS;
    localparam int FB   = `HPM_CNT_FIRST_BIT;

    // Defined bits of the mask registers
    localparam hpm_mask_t CNT_MASK = hpm_mask_t'(((1 << NCNT) - 1) << FB);
    localparam hpm_mask_t INH_MASK = CNT_MASK | hpm_mask_t'(1);  // Plus mcycle

    logic      ack_q;
    wb_data_t  dat_q;
    logic      req;         // New request this cycle
    logic      wr_en;
    wb_addr_t  adr_word;    // Byte address with low two bits dropped
    wb_data_t  rd_data;
    hpm_cnt_t  mcycle_q;
    hpm_mask_t inhibit_q;
    hpm_mask_t ovf_q;
    hpm_mask_t irq_en_q;
    hpm_mask_t ovf_set;
    hpm_mask_t ovf_clr;
    logic      wr_mcycle;
    logic      wr_inhibit;
    logic      wr_ovf;
    logic      wr_irq_en;

    // --------------------------------------------------
    // Handshake and decode
    // --------------------------------------------------
    assign req      = wb_cyc_i && wb_stb_i && !ack_q;  // One ack per access
    assign wr_en    = req && wb_we_i;
    assign adr_word = {wb_adr_i[`WB_ADDR_WIDTH-1:2], 2'b00};

    assign wr_mcycle  = wr_en && (adr_word == `HPM_ADDR_MCYCLE);
    assign wr_inhibit = wr_en && (adr_word == `HPM_ADDR_INHIBIT);
    assign wr_ovf     = wr_en && (adr_word == `HPM_ADDR_OVF);
    assign wr_irq_en  = wr_en && (adr_word == `HPM_ADDR_IRQ_EN);

    always_comb begin
        for (int k = 0; k < NCNT; k++) begin
            cnt_wr_o[k].cnt_we = wr_en &&
                (adr_word == wb_addr_t'(`HPM_ADDR_COUNTER_BASE + 4 * k));
            cnt_wr_o[k].sel_we = wr_en &&
                (adr_word == wb_addr_t'(`HPM_ADDR_EVSEL_BASE + 4 * k));
            cnt_wr_o[k].data   = wb_dat_i;  // Loaded unchanged
        end
    end

    // --------------------------------------------------
    // Read multiplexer
    // --------------------------------------------------
    always_comb begin
        rd_data = '0;                       // Unmapped reads 0
        case (adr_word)
            `HPM_ADDR_MCYCLE:  rd_data = wb_data_t'(mcycle_q);
            `HPM_ADDR_INHIBIT: rd_data = inhibit_q;
            `HPM_ADDR_OVF:     rd_data = ovf_q;
            `HPM_ADDR_IRQ_EN:  rd_data = irq_en_q;
            default:           rd_data = '0;
        endcase
        for (int k = 0; k < NCNT; k++) begin
            if (adr_word == wb_addr_t'(`HPM_ADDR_COUNTER_BASE + 4 * k)) begin
                rd_data = wb_data_t'(cnt_i[k]);
            end
            if (adr_word == wb_addr_t'(`HPM_ADDR_EVSEL_BASE + 4 * k)) begin
                rd_data = wb_data_t'(sel_i[k]);   // Zero extended
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_q <= 1'b0;
            dat_q <= '0;
        end else begin
            ack_q <= req;
            dat_q <= (req && !wb_we_i) ? rd_data : '0;  // Valid with ack
        end
    end

    // --------------------------------------------------
    // Cycle counter and control registers
    // --------------------------------------------------
    assign ovf_set = hpm_mask_t'(ovf_i) << FB;
    assign ovf_clr = wr_ovf ? (wb_dat_i & CNT_MASK) : '0;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mcycle_q  <= '0;
            inhibit_q <= '0;
            ovf_q     <= '0;
            irq_en_q  <= '0;
        end else begin
            if (wr_mcycle) begin
                mcycle_q <= hpm_cnt_t'(wb_dat_i);
            end else if (!inhibit_q[0]) begin
                mcycle_q <= mcycle_q + 1'b1;     // Free running cycles
            end
            if (wr_inhibit) begin
                inhibit_q <= wb_dat_i & INH_MASK;
            end
            if (wr_irq_en) begin
                irq_en_q <= wb_dat_i & CNT_MASK;
            end
            ovf_q <= (ovf_q & ~ovf_clr) | ovf_set;  // Set beats clear
        end
    end

    assign inhibit_o = inhibit_q[FB +: NCNT];
    assign ovf_irq_o = |(ovf_q & irq_en_q);
    assign wb_ack_o  = ack_q;
    assign wb_dat_o  = dat_q;

    // Master keeps the request up until it sees ack
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        ack_q |-> (wb_cyc_i && wb_stb_i))
        else $error("hpm_wb_regs: ack without cyc and stb");

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        ack_q |=> !ack_q)
        else $error("hpm_wb_regs: ack held for two cycles");

endmodule

// File: source/perf_monitor_top.sv
// Top of the hardware performance monitor
// Event capture, the counter bank and the Wishbone register block
`timescale 1ns/1ns

`include "hpm_defs.svh"

module perf_monitor_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  soft_rstn_i,
    input  hpm_pkg::core_events_t core_events_i,
    input  hpm_pkg::mem_events_t  mem_events_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  hpm_pkg::wb_addr_t     wb_adr_i,
    input  hpm_pkg::wb_data_t     wb_dat_i,
    output hpm_pkg::wb_data_t     wb_dat_o,
    output logic                  wb_ack_o,
    output logic                  ovf_irq_o
);

    import hpm_pkg::*;

    logic                                tile_rstn;  // Hard and soft reset
    hpm_events_t                         events_q;
    hpm_cnt_t   [`HPM_NUM_COUNTERS-1:0]  cnt;
    event_sel_t [`HPM_NUM_COUNTERS-1:0]  sel;
    logic       [`HPM_NUM_COUNTERS-1:0]  ovf;
    hpm_wr_t    [`HPM_NUM_COUNTERS-1:0]  cnt_wr;
    logic       [`HPM_NUM_COUNTERS-1:0]  inhibit;

    assign tile_rstn = rstn_i & soft_rstn_i;

    // --------------------------------------------------
    // Event capture, hard reset only
    // --------------------------------------------------
    hpm_event_capture event_capture_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .core_events_i (core_events_i),
        .mem_events_i  (mem_events_i),
        .events_o      (events_q)
    );

    // --------------------------------------------------
    // Counter bank
    // --------------------------------------------------
    for (genvar k = 0; k < `HPM_NUM_COUNTERS; k++) begin : gen_counter
        hpm_counter counter_inst (
            .clk_i     (clk_i),
            .rstn_i    (tile_rstn),
            .events_i  (events_q),
            .inhibit_i (inhibit[k]),
            .wr_i      (cnt_wr[k]),
            .count_o   (cnt[k]),
            .sel_o     (sel[k]),
            .ovf_o     (ovf[k])
        );
    end

    // --------------------------------------------------
    // Register block
    // --------------------------------------------------
    hpm_wb_regs wb_regs_inst (
        .clk_i     (clk_i),
        .rstn_i    (tile_rstn),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .cnt_i     (cnt),
        .sel_i     (sel),
        .ovf_i     (ovf),
        .cnt_wr_o  (cnt_wr),
        .inhibit_o (inhibit),
        .ovf_irq_o (ovf_irq_o)
    );

endmodule

// File: verification/tb_perf_monitor.sv
// Directed testbench for the performance monitor, drives events and the
// Wishbone bus on the falling edge and checks counters, overflow and resets
`timescale 1ns/1ns

`include "hpm_defs.svh"

module tb_perf_monitor;

    import hpm_pkg::*;

    localparam int NCNT    = `HPM_NUM_COUNTERS;
    localparam int FB      = `HPM_CNT_FIRST_BIT;
    localparam int TIMEOUT = 20;                // Cycles to wait for ack

    logic         clk_i;
    logic         rstn_i;
    logic         soft_rstn_i;
    core_events_t core_events_i;
    mem_events_t  mem_events_i;
    logic         wb_cyc_i;
    logic         wb_stb_i;
    logic         wb_we_i;
    wb_addr_t     wb_adr_i;
    wb_data_t     wb_dat_i;
    wb_data_t     wb_dat_o;
    logic         wb_ack_o;
    logic         ovf_irq_o;

    integer seed = 32'he7da083b;                // Event pattern seed
    string  cur_test;
    int     test_errs;                          // Mismatches in the running test
    int     tests_passed;
    int     tests_failed;

    perf_monitor_top perf_monitor_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .soft_rstn_i   (soft_rstn_i),
        .core_events_i (core_events_i),
        .mem_events_i  (mem_events_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .ovf_irq_o     (ovf_irq_o)
    );

    always #4 clk_i = ~clk_i;                   // 8 ns period

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic wb_addr_t cnt_adr(input int k);
        return wb_addr_t'(`HPM_ADDR_COUNTER_BASE + 4 * k);
    endfunction

    function automatic wb_addr_t sel_adr(input int k);
        return wb_addr_t'(`HPM_ADDR_EVSEL_BASE + 4 * k);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $finish;
    endtask

    // Bit i-1 of ev is event number i
    task automatic set_events(input logic [15:0] ev);
        core_events_i.branch_miss  = ev[0];
        core_events_i.is_branch    = ev[1];
        core_events_i.branch_taken = ev[2];
        core_events_i.stall_if     = ev[3];
        core_events_i.stall_id     = ev[4];
        core_events_i.stall_exe    = ev[5];
        core_events_i.stall_wb     = ev[6];
        core_events_i.load_store   = ev[7];
        mem_events_i.icache_req    = ev[8];
        mem_events_i.icache_miss   = ev[9];
        mem_events_i.dcache_read   = ev[10];
        mem_events_i.dcache_write  = ev[11];
        mem_events_i.dcache_miss   = ev[12];
        mem_events_i.itlb_miss     = ev[13];
        mem_events_i.dtlb_miss     = ev[14];
        mem_events_i.dcache_stall  = ev[15];
    endtask

    task automatic idle_cycles(input int n);
        set_events('0);
        repeat (n) @(negedge clk_i);
    endtask

    // One classic cycle, request held through the edge that sees ack
    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                             output wb_data_t rdat);
        int n;
        n    = 0;
        rdat = '0;
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        @(negedge clk_i);
        while (!wb_ack_o && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!wb_ack_o) begin
            abort_run($sformatf("No Wishbone ack for offset 0x%02h within %0d cycles",
                                adr, TIMEOUT));
        end else begin
            check_value("ack latency", 0, n);   // Ack one cycle after stb
            rdat = wb_dat_o;                    // Valid while ack is high
            @(negedge clk_i);
            check_value("ack single cycle", 0, wb_ack_o);
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
            wb_we_i  = 1'b0;
        end
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic read_check(input wb_addr_t adr, input wb_data_t exp, input string what);
        wb_data_t dat;
        wb_read(adr, dat);
        check_value(what, exp, dat);
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic report_test();
        if (test_errs == 0) begin
            $display("[%s] pass", cur_test);
            tests_passed++;
        end else begin
            $display("[%s] fail, %0d mismatches", cur_test, test_errs);
            tests_failed++;
        end
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic reset_state_test();
        start_test("reset_state");
        for (int k = 0; k < NCNT; k++) begin
            read_check(cnt_adr(k), 0, $sformatf("counter %0d", k));
            read_check(sel_adr(k), 0, $sformatf("selector %0d", k));
        end
        read_check(`HPM_ADDR_INHIBIT, 0, "inhibit");
        read_check(`HPM_ADDR_OVF, 0, "overflow status");
        read_check(`HPM_ADDR_IRQ_EN, 0, "irq enable");
        read_check(8'h30, 0, "unmapped 0x30");
        read_check(8'hFC, 0, "unmapped 0xFC");
        check_value("ovf_irq_o", 0, ovf_irq_o);
        report_test();
    endtask

    task automatic event_count_test();
        wb_data_t    sel_wr [NCNT];
        logic [31:0] expc [NCNT];               // Expected counts from the pattern
        logic [15:0] pat;
        int          s;
        start_test("event_counting");
        sel_wr = '{32'd3, 32'd0, 32'h2B, 32'd16};  // 0x2B keeps 11 in 5 bits
        for (int k = 0; k < NCNT; k++) begin
            wb_write(sel_adr(k), sel_wr[k]);
            wb_write(cnt_adr(k), 0);
            expc[k] = 0;
        end
        for (int k = 0; k < NCNT; k++) begin
            read_check(sel_adr(k), sel_wr[k] & 32'h1F, $sformatf("selector %0d", k));
        end
        repeat (64) begin
            @(negedge clk_i);
            pat = 16'($random(seed));
            set_events(pat);
            for (int k = 0; k < NCNT; k++) begin
                s = int'(sel_wr[k] & 32'h1F);
                if (s != 0 && pat[s-1]) begin
                    expc[k]++;
                end
            end
        end
        @(negedge clk_i);                       // Last pattern held one cycle
        idle_cycles(4);
        for (int k = 0; k < NCNT; k++) begin
            read_check(cnt_adr(k), expc[k], $sformatf("counter %0d", k));
        end
        report_test();
    endtask

    task automatic inhibit_test();
        wb_data_t m1;
        wb_data_t m2;
        start_test("inhibit");
        wb_write(sel_adr(1), 32'd5);
        wb_write(cnt_adr(0), 0);
        wb_write(cnt_adr(1), 0);
        wb_write(`HPM_ADDR_INHIBIT, 32'(1) << (FB + 1));
        read_check(`HPM_ADDR_INHIBIT, 32'h10, "inhibit readback");
        set_events(16'h0014);                   // Events 3 and 5
        repeat (10) @(negedge clk_i);
        idle_cycles(4);
        read_check(cnt_adr(0), 10, "counter 0 free");
        read_check(cnt_adr(1), 0, "counter 1 inhibited");
        wb_write(`HPM_ADDR_INHIBIT, 32'hFFFF_FFFF);
        read_check(`HPM_ADDR_INHIBIT, 32'h79, "inhibit defined bits");
        wb_write(`HPM_ADDR_INHIBIT, 32'h1);     // mcycle only
        wb_read(`HPM_ADDR_MCYCLE, m1);
        wb_read(`HPM_ADDR_MCYCLE, m2);
        check_value("mcycle held", m1, m2);
        wb_write(`HPM_ADDR_INHIBIT, 0);
        wb_read(`HPM_ADDR_MCYCLE, m1);
        wb_read(`HPM_ADDR_MCYCLE, m2);
        check_value("mcycle advancing", 1, m2 > m1);
        report_test();
    endtask

    task automatic overflow_irq_test();
        start_test("overflow_irq");
        wb_write(cnt_adr(2), 32'hFFFF_FFFD);
        set_events(16'h0400);                   // Event 11, counter 2
        repeat (5) @(negedge clk_i);
        idle_cycles(4);
        read_check(cnt_adr(2), 2, "counter 2 after wrap");
        read_check(`HPM_ADDR_OVF, 32'h20, "overflow status");
        check_value("irq before enable", 0, ovf_irq_o);
        wb_write(`HPM_ADDR_IRQ_EN, 32'h20);
        check_value("irq after enable", 1, ovf_irq_o);
        read_check(`HPM_ADDR_IRQ_EN, 32'h20, "irq enable readback");
        wb_write(`HPM_ADDR_OVF, 32'h20);        // Write 1 to clear
        check_value("irq after clear", 0, ovf_irq_o);
        read_check(`HPM_ADDR_OVF, 0, "overflow after clear");
        report_test();
    endtask

    task automatic soft_reset_test();
        start_test("soft_reset");
        wb_write(cnt_adr(3), 32'hFFFF_FFFF);
        wb_write(`HPM_ADDR_IRQ_EN, 32'h40);
        wb_write(`HPM_ADDR_INHIBIT, 32'h08);
        set_events(16'h8000);                   // Event 16 wraps counter 3
        @(negedge clk_i);
        idle_cycles(3);
        check_value("irq before soft reset", 1, ovf_irq_o);
        soft_rstn_i = 1'b0;
        repeat (2) @(negedge clk_i);
        soft_rstn_i = 1'b1;
        check_value("irq after soft reset", 0, ovf_irq_o);
        for (int k = 0; k < NCNT; k++) begin
            read_check(cnt_adr(k), 0, $sformatf("counter %0d", k));
            read_check(sel_adr(k), 0, $sformatf("selector %0d", k));
        end
        read_check(`HPM_ADDR_INHIBIT, 0, "inhibit");
        read_check(`HPM_ADDR_OVF, 0, "overflow status");
        read_check(`HPM_ADDR_IRQ_EN, 0, "irq enable");
        report_test();
    endtask

    task automatic write_precedence_test();
        wb_data_t v1;
        start_test("write_precedence");
        wb_write(sel_adr(0), 32'd3);
        set_events(16'h0004);                   // Steady event 3 stream
        repeat (3) @(negedge clk_i);
        wb_write(cnt_adr(0), 32'd1000);
        idle_cycles(4);
        wb_read(cnt_adr(0), v1);
        // Write edge wins, at most two stream cycles land after it
        check_value($sformatf("count 0x%08h in 1000..1002", v1), 1,
                    (v1 >= 32'd1000) && (v1 <= 32'd1002));
        set_events(16'h0004);
        repeat (7) @(negedge clk_i);
        idle_cycles(4);
        read_check(cnt_adr(0), v1 + 32'd7, "growth after write");
        report_test();
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        clk_i        = 1'b0;
        rstn_i       = 1'b0;
        soft_rstn_i  = 1'b1;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        tests_passed = 0;
        tests_failed = 0;
        set_events('0);
        repeat (2) @(negedge clk_i);            // Hard reset for 2 cycles
        rstn_i = 1'b1;

        reset_state_test();
        event_count_test();
        inhibit_test();
        overflow_irq_test();
        soft_reset_test();
        write_precedence_test();

        $display("Summary: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
